// ==== flist.f ====
verilog/uart_pkg.sv
verilog/game_link_pkg.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_game_encoder.sv
verilog/uart_game_decoder.sv
verilog/game_link_top.sv
bench/game_link_props.sv
bench/game_link_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build with Verilator, run, and decide the result from the simulation output.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module game_link_tb -f flist.f -o game_link_sim \
    && ./obj_dir/game_link_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== bench/game_link_tb.sv ====
`default_nettype none

module game_link_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int bit_cycles = 8;

    logic clk = 1'b0;
    logic reset;
    logic send;
    logic [11:0] char_x;
    logic [11:0] char_y;
    logic [3:0] char_hp;
    logic [3:0] char_aggro;
    logic [1:0] char_class;
    logic flip_h;
    logic [6:0] boss_hp;
    logic [11:0] boss_x;
    logic [11:0] boss_y;
    logic tx;
    logic rx;
    logic [11:0] player_2_x;
    logic [11:0] player_2_y;
    logic [3:0] player_2_hp;
    logic [3:0] player_2_aggro;
    logic [1:0] player_2_class;
    logic player_2_flip_h;
    logic [11:0] boss_out_x;
    logic [11:0] boss_out_y;
    logic [6:0] boss_out_hp;
    logic data_valid;

    logic loopback;
    logic bang_line;
    logic [65:0] frames [$];
    int seed = 32'h698c_6078;
    int errors = 0;

    assign rx = loopback ? tx : bang_line; // Either the own transmitter or injected bytes.

    always #2 clk = ~clk;

    game_link_top #(
        .clks_per_bit(bit_cycles),
        .fifo_depth_log2(4)
    ) game_link_top_i (
        .clk(clk),
        .reset(reset),
        .send(send),
        .char_x(char_x),
        .char_y(char_y),
        .char_hp(char_hp),
        .char_aggro(char_aggro),
        .char_class(char_class),
        .flip_h(flip_h),
        .boss_hp(boss_hp),
        .boss_x(boss_x),
        .boss_y(boss_y),
        .tx(tx),
        .rx(rx),
        .player_2_x(player_2_x),
        .player_2_y(player_2_y),
        .player_2_hp(player_2_hp),
        .player_2_aggro(player_2_aggro),
        .player_2_class(player_2_class),
        .player_2_flip_h(player_2_flip_h),
        .boss_out_x(boss_out_x),
        .boss_out_y(boss_out_y),
        .boss_out_hp(boss_out_hp),
        .data_valid(data_valid)
    );

    function automatic logic [65:0] sent_fields();
        return {char_x, char_y, char_hp, char_aggro, char_class, flip_h, boss_x, boss_y, boss_hp};
    endfunction

    function automatic logic [65:0] peer_fields();
        return {player_2_x, player_2_y, player_2_hp, player_2_aggro, player_2_class,
                player_2_flip_h, boss_out_x, boss_out_y, boss_out_hp};
    endfunction

    // Every accepted frame is recorded with the fields it published.
    always @(posedge clk) begin
        if (data_valid) begin
            frames.push_back(peer_fields());
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [65:0] expected,
                                 input logic [65:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("Error: %s", what);
        end
    endtask

    task automatic roll_local_state();
        logic [31:0] rnd;
        rnd = $random(seed);
        char_x = rnd[11:0];
        char_y = rnd[23:12];
        char_hp = rnd[27:24];
        char_aggro = rnd[31:28];
        rnd = $random(seed);
        boss_x = rnd[11:0];
        boss_y = rnd[23:12];
        boss_hp = rnd[30:24];
        flip_h = rnd[31];
        rnd = $random(seed);
        char_class = rnd[1:0];
    endtask

    task automatic strobe_send();
        send = 1'b1;
        next_cycle();
        send = 1'b0;
    endtask

    task automatic wait_for_frames(input int count, input int limit, output logic reached);
        int cycles;
        cycles = 0;
        while (frames.size() < count && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        reached = (frames.size() >= count);
    endtask

    task automatic bang_byte(input logic [7:0] value);
        logic [9:0] bits;
        bits = {1'b1, value, 1'b0}; // Start bit first, then LSB first, then stop.
        for (int k = 0; k < 10; k++) begin
            bang_line = bits[k];
            repeat (bit_cycles) next_cycle();
        end
    endtask

    task automatic inject_frame(input logic [7:0] csum_flip);
        logic [7:0] bytes [0:12];
        logic [7:0] sum;
        bytes[0] = 8'hA5;
        bytes[1] = {4'h0, char_x[11:8]};
        bytes[2] = char_x[7:0];
        bytes[3] = {4'h0, char_y[11:8]};
        bytes[4] = char_y[7:0];
        bytes[5] = {char_hp, char_aggro};
        bytes[6] = {5'b0, flip_h, char_class};
        bytes[7] = {1'b0, boss_hp};
        bytes[8] = {4'h0, boss_x[11:8]};
        bytes[9] = boss_x[7:0];
        bytes[10] = {4'h0, boss_y[11:8]};
        bytes[11] = boss_y[7:0];
        sum = 8'h00;
        for (int k = 1; k < 12; k++) begin
            sum = sum ^ bytes[k];
        end
        bytes[12] = sum ^ csum_flip;
        for (int k = 0; k < 13; k++) begin
            bang_byte(bytes[k]);
        end
    endtask

    initial begin
        logic [65:0] first;
        logic [65:0] second;
        logic [65:0] held;
        logic reached;
        int base;
        int prop_fails;

        reset = 1'b1;
        send = 1'b0;
        loopback = 1'b1;
        bang_line = 1'b1;
        char_x = '0;
        char_y = '0;
        char_hp = '0;
        char_aggro = '0;
        char_class = '0;
        flip_h = 1'b0;
        boss_hp = '0;
        boss_x = '0;
        boss_y = '0;
        repeat (5) next_cycle();
        reset = 1'b0;
        next_cycle();

        compare_value("reset tx", 66'd1, {65'd0, tx});
        compare_value("reset data_valid", 66'd0, {65'd0, data_valid});
        compare_value("reset peer fields", 66'd0, peer_fields());

        roll_local_state();
        base = frames.size();
        strobe_send();
        first = sent_fields();
        wait_for_frames(base + 1, 3000, reached);
        require(reached, "timeout waiting for the loopback frame");
        if (reached) begin
            compare_value("loopback", first, frames[base]);
        end

        roll_local_state();
        base = frames.size();
        strobe_send();
        first = sent_fields();
        roll_local_state();
        repeat (14) next_cycle(); // The first frame is in the FIFO after 13 writes.
        strobe_send();
        second = sent_fields();
        wait_for_frames(base + 2, 4000, reached);
        require(reached, "timeout waiting for two back-to-back frames");
        if (reached) begin
            compare_value("back-to-back first", first, frames[base]);
            compare_value("back-to-back second", second, frames[base + 1]);
        end

        loopback = 1'b0;
        held = peer_fields();
        roll_local_state();
        base = frames.size();
        inject_frame(8'h5C);
        wait_for_frames(base + 1, 400, reached);
        require(!reached, "data_valid pulsed for a frame with a bad checksum");
        compare_value("bad checksum hold", held, peer_fields());

        base = frames.size();
        bang_byte(8'h3C);
        bang_byte(8'h00);
        bang_byte(8'hFF);
        bang_byte(8'h5A);
        roll_local_state();
        inject_frame(8'h00);
        wait_for_frames(base + 1, 400, reached);
        require(reached, "timeout waiting for the frame after noise");
        if (reached) begin
            compare_value("noise then frame", sent_fields(), frames[base]);
        end
        wait_for_frames(base + 2, 400, reached);
        require(!reached, "more than one data_valid after the noisy stream");

        prop_fails = game_link_top_i.u_uart_decoder.decoder_props.fail_count +
                     game_link_top_i.u_uart_tx.tx_props.fail_count;
        $display("Run complete with %0d check errors and %0d property failures",
                 errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/game_link_props.sv ====
`default_nettype none

module game_link_props (
    input logic        clk,
    input logic        reset,
    input logic        data_valid,
    input logic [65:0] fields,
    input logic        tx_idle,
    input logic        tx
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    valid_single_pulse: assert property (@(posedge clk) disable iff (reset)
        data_valid |=> !data_valid)
        else begin
            fail_count++;
            $error("data_valid stayed high for more than one cycle");
        end

    line_high_when_idle: assert property (@(posedge clk) disable iff (reset)
        tx_idle |-> tx)
        else begin
            fail_count++;
            $error("tx went low while the transmitter was idle");
        end

    fields_hold: assert property (@(posedge clk) disable iff (reset)
        !data_valid |-> $stable(fields))
        else begin
            fail_count++;
            $error("peer fields changed outside a data_valid cycle");
        end

endmodule

bind uart_game_decoder game_link_props decoder_props (
    .clk(clk),
    .reset(reset),
    .data_valid(data_valid),
    .fields({player_2_x, player_2_y, player_2_hp, player_2_aggro, player_2_class,
             player_2_flip_h, boss_out_x, boss_out_y, boss_out_hp}),
    .tx_idle(1'b0),
    .tx(1'b1)
);

bind uart_tx game_link_props tx_props (
    .clk(clk),
    .reset(reset),
    .data_valid(1'b0),
    .fields(66'd0),
    .tx_idle(state == uart_pkg::tx_idle),
    .tx(tx)
);

`default_nettype wire

// ==== verilog/game_link_top.sv ====
`default_nettype none

module game_link_top #(
    parameter int clks_per_bit = 35,
    parameter int fifo_depth_log2 = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                send,
    input  logic [game_link_pkg::coord_w-1:0]   char_x,
    input  logic [game_link_pkg::coord_w-1:0]   char_y,
    input  logic [game_link_pkg::hp_w-1:0]      char_hp,
    input  logic [game_link_pkg::aggro_w-1:0]   char_aggro,
    input  logic [game_link_pkg::class_w-1:0]   char_class,
    input  logic                                flip_h,
    input  logic [game_link_pkg::boss_hp_w-1:0] boss_hp,
    input  logic [game_link_pkg::coord_w-1:0]   boss_x,
    input  logic [game_link_pkg::coord_w-1:0]   boss_y,
    output logic                                tx,
    input  logic                                rx,
    output logic [game_link_pkg::coord_w-1:0]   player_2_x,
    output logic [game_link_pkg::coord_w-1:0]   player_2_y,
    output logic [game_link_pkg::hp_w-1:0]      player_2_hp,
    output logic [game_link_pkg::aggro_w-1:0]   player_2_aggro,
    output logic [game_link_pkg::class_w-1:0]   player_2_class,
    output logic                                player_2_flip_h,
    output logic [game_link_pkg::coord_w-1:0]   boss_out_x,
    output logic [game_link_pkg::coord_w-1:0]   boss_out_y,
    output logic [game_link_pkg::boss_hp_w-1:0] boss_out_hp,
    output logic                                data_valid
);

    logic [7:0] wr_data;
    logic       wr;
    logic       full;
    logic [7:0] rd_data;
    logic       rd;
    logic       empty;
    logic [7:0] rx_byte;
    logic       rx_strobe;

    uart_game_encoder u_uart_encoder (
        .clk(clk),
        .reset(reset),
        .send(send),
        .char_x(char_x),
        .char_y(char_y),
        .char_hp(char_hp),
        .char_aggro(char_aggro),
        .char_class(char_class),
        .flip_h(flip_h),
        .boss_hp(boss_hp),
        .boss_x(boss_x),
        .boss_y(boss_y),
        .full(full),
        .wr(wr),
        .wr_data(wr_data)
    );

    uart_fifo #(
        .fifo_depth_log2(fifo_depth_log2)
    ) u_uart_fifo (
        .clk(clk),
        .reset(reset),
        .wr(wr),
        .wr_data(wr_data),
        .full(full),
        .rd(rd),
        .rd_data(rd_data),
        .empty(empty)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_tx (
        .clk(clk),
        .reset(reset),
        .empty(empty),
        .rd(rd),
        .rd_data(rd_data),
        .tx(tx)
    );

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_rx (
        .clk(clk),
        .reset(reset),
        .rx(rx),
        .rx_byte(rx_byte),
        .rx_strobe(rx_strobe)
    );

    uart_game_decoder u_uart_decoder (
        .clk(clk),
        .reset(reset),
        .rx_byte(rx_byte),
        .rx_strobe(rx_strobe),
        .player_2_x(player_2_x),
        .player_2_y(player_2_y),
        .player_2_hp(player_2_hp),
        .player_2_aggro(player_2_aggro),
        .player_2_class(player_2_class),
        .player_2_flip_h(player_2_flip_h),
        .boss_out_x(boss_out_x),
        .boss_out_y(boss_out_y),
        .boss_out_hp(boss_out_hp),
        .data_valid(data_valid)
    );

endmodule

`default_nettype wire

// ==== verilog/uart_game_decoder.sv ====
`default_nettype none

module uart_game_decoder (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [7:0]                          rx_byte,
    input  logic                                rx_strobe,
    output logic [game_link_pkg::coord_w-1:0]   player_2_x,
    output logic [game_link_pkg::coord_w-1:0]   player_2_y,
    output logic [game_link_pkg::hp_w-1:0]      player_2_hp,
    output logic [game_link_pkg::aggro_w-1:0]   player_2_aggro,
    output logic [game_link_pkg::class_w-1:0]   player_2_class,
    output logic                                player_2_flip_h,
    output logic [game_link_pkg::coord_w-1:0]   boss_out_x,
    output logic [game_link_pkg::coord_w-1:0]   boss_out_y,
    output logic [game_link_pkg::boss_hp_w-1:0] boss_out_hp,
    output logic                                data_valid
);

    localparam int body_last = game_link_pkg::frame_bytes - 3;

    game_link_pkg::parse_state_t state;
    logic [7:0] shadow [0:body_last];
    logic [3:0] idx;
    logic [7:0] csum;

    always_ff @(posedge clk) begin
        if (state == game_link_pkg::parse_body && rx_strobe) begin
            shadow[idx] <= rx_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= game_link_pkg::parse_hunt;
            idx             <= '0;
            csum            <= '0;
            data_valid      <= 1'b0;
            player_2_x      <= '0;
            player_2_y      <= '0;
            player_2_hp     <= '0;
            player_2_aggro  <= '0;
            player_2_class  <= '0;
            player_2_flip_h <= 1'b0;
            boss_out_x      <= '0;
            boss_out_y      <= '0;
            boss_out_hp     <= '0;
        end else begin
            data_valid <= 1'b0;
            case (state)
                game_link_pkg::parse_hunt: begin
                    idx  <= '0;
                    csum <= '0;
                    if (rx_strobe && rx_byte == game_link_pkg::frame_header) begin
                        state <= game_link_pkg::parse_body;
                    end
                end
                game_link_pkg::parse_body: begin
                    if (rx_strobe) begin
                        csum <= csum ^ rx_byte;
                        idx  <= idx + 1'b1;
                        if (idx == 4'(body_last)) begin
                            state <= game_link_pkg::parse_check;
                        end
                    end
                end
                default: begin
                    if (rx_strobe) begin
                        state <= game_link_pkg::parse_hunt;
                        if (rx_byte == csum) begin // Bad frames leave the old state in place.
                            data_valid      <= 1'b1;
                            player_2_x      <= {shadow[0][3:0], shadow[1]};
                            player_2_y      <= {shadow[2][3:0], shadow[3]};
                            player_2_hp     <= shadow[4][7:4];
                            player_2_aggro  <= shadow[4][3:0];
                            player_2_class  <= shadow[5][1:0];
                            player_2_flip_h <= shadow[5][2];
                            boss_out_hp     <= shadow[6][6:0];
                            boss_out_x      <= {shadow[7][3:0], shadow[8]};
                            boss_out_y      <= {shadow[9][3:0], shadow[10]};
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_game_encoder.sv ====
`default_nettype none

module uart_game_encoder (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                send,
    input  logic [game_link_pkg::coord_w-1:0]   char_x,
    input  logic [game_link_pkg::coord_w-1:0]   char_y,
    input  logic [game_link_pkg::hp_w-1:0]      char_hp,
    input  logic [game_link_pkg::aggro_w-1:0]   char_aggro,
    input  logic [game_link_pkg::class_w-1:0]   char_class,
    input  logic                                flip_h,
    input  logic [game_link_pkg::boss_hp_w-1:0] boss_hp,
    input  logic [game_link_pkg::coord_w-1:0]   boss_x,
    input  logic [game_link_pkg::coord_w-1:0]   boss_y,
    input  logic                                full,
    output logic                                wr,
    output logic [7:0]                          wr_data
);

    localparam int body_last = game_link_pkg::frame_bytes - 2;

    game_link_pkg::frame_state_t state;
    logic [7:0] fields [0:body_last];
    logic [7:0] snap [0:body_last];
    logic [3:0] idx;
    logic [7:0] csum;

    always_comb begin
        fields[0]  = game_link_pkg::frame_header;
        fields[1]  = {4'b0, char_x[11:8]};
        fields[2]  = char_x[7:0];
        fields[3]  = {4'b0, char_y[11:8]};
        fields[4]  = char_y[7:0];
        fields[5]  = {char_hp, char_aggro};
        fields[6]  = {5'b0, flip_h, char_class};
        fields[7]  = {1'b0, boss_hp};
        fields[8]  = {4'b0, boss_x[11:8]};
        fields[9]  = boss_x[7:0];
        fields[10] = {4'b0, boss_y[11:8]};
        fields[11] = boss_y[7:0];
    end

    assign wr      = (state != game_link_pkg::frame_idle) && !full;
    assign wr_data = (state == game_link_pkg::frame_last) ? csum : snap[idx];

    always_ff @(posedge clk) begin
        if (state == game_link_pkg::frame_idle && send) begin
            for (int i = 0; i <= body_last; i++) begin
                snap[i] <= fields[i]; // Frame stays coherent while the game moves on.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= game_link_pkg::frame_idle;
            idx   <= '0;
            csum  <= '0;
        end else begin
            case (state)
                game_link_pkg::frame_idle: begin
                    idx  <= '0;
                    csum <= '0;
                    if (send) begin
                        state <= game_link_pkg::frame_send;
                    end
                end
                game_link_pkg::frame_send: begin
                    if (!full) begin
                        if (idx != '0) begin
                            csum <= csum ^ snap[idx]; // The header is not summed.
                        end
                        idx <= idx + 1'b1;
                        if (idx == 4'(body_last)) begin
                            state <= game_link_pkg::frame_last;
                        end
                    end
                end
                default: begin
                    if (!full) begin
                        state <= game_link_pkg::frame_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`default_nettype none

module uart_rx #(
    parameter int clks_per_bit = 35
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    localparam int cnt_w = $clog2(clks_per_bit);

    uart_pkg::rx_state_t state;
    logic rx_meta;
    logic rx_sync;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0] bit_cnt;
    logic bit_done;
    logic half_done;

    assign bit_done  = (baud_cnt == cnt_w'(clks_per_bit - 1));
    assign half_done = (baud_cnt == cnt_w'(clks_per_bit / 2 - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= uart_pkg::rx_idle;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            baud_cnt  <= baud_cnt + 1'b1;
            case (state)
                uart_pkg::rx_idle: begin
                    baud_cnt <= '0;
                    if (!rx_sync) begin
                        state <= uart_pkg::rx_start;
                    end
                end
                uart_pkg::rx_start: begin
                    if (half_done) begin
                        baud_cnt <= '0; // From here on samples fall at mid-bit.
                        bit_cnt  <= '0;
                        state    <= rx_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;
                    end
                end
                uart_pkg::rx_data: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        rx_byte  <= {rx_sync, rx_byte[7:1]}; // LSB arrives first.
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= uart_pkg::rx_stop;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        rx_strobe <= rx_sync; // A low stop bit is a framing error.
                        state     <= uart_pkg::rx_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 35
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       empty,
    output logic       rd,
    input  logic [7:0] rd_data,
    output logic       tx
);

    localparam int cnt_w = $clog2(clks_per_bit);

    uart_pkg::tx_state_t state;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic baud_done;

    assign baud_done = (baud_cnt == cnt_w'(clks_per_bit - 1));
    assign rd = (state == uart_pkg::tx_idle) && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= uart_pkg::tx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else begin
            baud_cnt <= (state == uart_pkg::tx_idle || baud_done) ? '0 : baud_cnt + 1'b1;
            case (state)
                uart_pkg::tx_idle: begin
                    if (!empty) begin
                        state <= uart_pkg::tx_start;
                        tx    <= 1'b0;
                    end
                end
                uart_pkg::tx_start: begin
                    if (baud_cnt == '0) begin
                        shift <= rd_data; // FIFO output has settled by now.
                    end
                    if (baud_done) begin
                        state   <= uart_pkg::tx_data;
                        bit_cnt <= '0;
                        tx      <= shift[0];
                        shift   <= shift >> 1;
                    end
                end
                uart_pkg::tx_data: begin
                    if (baud_done) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= uart_pkg::tx_stop;
                            tx    <= 1'b1;
                        end else begin
                            tx    <= shift[0];
                            shift <= shift >> 1;
                        end
                    end
                end
                default: begin
                    if (baud_done) begin
                        state <= uart_pkg::tx_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_fifo.sv ====
`default_nettype none

module uart_fifo #(
    parameter int fifo_depth_log2 = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr,
    input  logic [7:0] wr_data,
    output logic       full,
    input  logic       rd,
    output logic [7:0] rd_data,
    output logic       empty
);

    localparam int depth = 1 << fifo_depth_log2;

    logic [7:0] mem [0:depth-1];
    logic [fifo_depth_log2:0] wr_ptr; // Extra bit tells a full buffer from an empty one.
    logic [fifo_depth_log2:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[fifo_depth_log2] != rd_ptr[fifo_depth_log2]) &&
                   (wr_ptr[fifo_depth_log2-1:0] == rd_ptr[fifo_depth_log2-1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !full) begin
            mem[wr_ptr[fifo_depth_log2-1:0]] <= wr_data;
        end
        if (rd && !empty) begin
            rd_data <= mem[rd_ptr[fifo_depth_log2-1:0]]; // Valid the cycle after rd.
        end
    end

endmodule

`default_nettype wire

// ==== verilog/game_link_pkg.sv ====
`default_nettype none

package game_link_pkg;

    localparam logic [7:0] frame_header = 8'hA5; // Sync byte that opens every frame.
    localparam int frame_bytes = 13;             // Header, eleven payload bytes, checksum.

    localparam int coord_w = 12;
    localparam int hp_w = 4;
    localparam int aggro_w = 4;
    localparam int class_w = 2;
    localparam int boss_hp_w = 7;

    typedef enum logic [1:0] {
        frame_idle,
        frame_send,
        frame_last
    } frame_state_t;

    typedef enum logic [1:0] {
        parse_hunt,
        parse_body,
        parse_check
    } parse_state_t;

endpackage

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

endpackage

`default_nettype wire
